// ==== files.f ====
hw/key_pkg.sv
hw/key_filter.sv
hw/key_event_encoder.sv
hw/counter_ctrl.sv
hw/seg_scanner.sv
hw/key_panel_top.sv
dv/tb_clock.sv
dv/key_panel_assertions.sv
dv/key_panel_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := key_panel_tb
FILELIST   := files.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Checks failed
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/key_panel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_panel_tb;
	import key_pkg::*;

	localparam int HOLD = 20;
	localparam int WAIT_LIMIT = 2 * HOLD + 64;
	// Length of each test in hold periods, summed for the timeout.
	localparam int PRESS_HOLDS = 20;
	localparam int TEST_HOLDS = 4 + 7 * PRESS_HOLDS + 5 * PRESS_HOLDS
		+ 7 * PRESS_HOLDS + 4 * PRESS_HOLDS;
	localparam int TIMEOUT_CYCLES = TEST_HOLDS * HOLD + 1000;

	logic clk;
	logic rst_n;
	logic [NUM_KEYS-1:0] keys;
	logic [6:0] seg;
	logic [1:0] dig;
	logic locked;
	logic [NUM_KEYS-1:0] key_down;

	logic [7:0] lfsr;
	logic [VALUE_W-1:0] exp_value;
	logic exp_locked;
	int errors;
	int checks;
	int tests;
	int test_errors;
	int cycles = 0;
	string test_name;

	tb_clock u_clock (
		.clk(clk)
	);

	key_panel_top #(
		.DEBOUNCE_CYCLES(HOLD)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.keys(keys),
		.seg(seg),
		.dig(dig),
		.locked(locked),
		.key_down(key_down)
	);

	// ------------------------------------------------------------
	// Stimulus helpers.
	// ------------------------------------------------------------
	// Taps x^8 + x^6 + x^5 + x^4 + 1.
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Level 1 is released.
	task automatic drive_keys(input logic [NUM_KEYS-1:0] mask, input logic level);
		@(posedge clk);
		if (level) begin
			keys <= keys | mask;
		end else begin
			keys <= keys & ~mask;
		end
	endtask

	// Glitches last at most 17 cycles, below the hold count.
	task automatic drive_edge(input logic [NUM_KEYS-1:0] mask, input logic level,
		input bit bouncy);
		int len;
		if (bouncy) begin
			for (int g = 0; g < 3; g++) begin
				draw_bits(4, len);
				drive_keys(mask, level);
				wait_cycles(len + 1);
				draw_bits(4, len);
				drive_keys(mask, !level);
				wait_cycles(len + 1);
			end
		end
		drive_keys(mask, level);
	endtask

	task automatic wait_key_down(input logic [NUM_KEYS-1:0] exp);
		int n;
		n = 0;
		@(negedge clk);
		while (key_down !== exp && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (key_down !== exp) begin
			errors++;
			$display("Key filter did not settle to %b in test %s", exp, test_name);
		end
	endtask

	// ------------------------------------------------------------
	// Reference model.
	// ------------------------------------------------------------
	function automatic opcode_e key_opcode(input int idx);
		case (idx)
			0: return OP_INC;
			1: return OP_DEC;
			2: return OP_CLEAR;
			default: return OP_LOCK;
		endcase
	endfunction

	task automatic model_op(input opcode_e op);
		case (op)
			OP_INC: begin
				if (!exp_locked) begin
					exp_value = exp_value + VALUE_W'(1);
				end
			end
			OP_DEC: begin
				if (!exp_locked) begin
					exp_value = exp_value - VALUE_W'(1);
				end
			end
			OP_CLEAR: exp_value = '0;
			OP_LOCK: exp_locked = !exp_locked;
			default: exp_value = exp_value;
		endcase
	endtask

	// Simultaneous keys are applied in index order.
	task automatic press_keys(input logic [NUM_KEYS-1:0] mask, input bit bouncy);
		drive_edge(mask, 1'b0, bouncy);
		wait_key_down(mask);
		for (int i = 0; i < NUM_KEYS; i++) begin
			if (mask[i]) begin
				model_op(key_opcode(i));
			end
		end
		drive_edge(mask, 1'b1, bouncy);
		wait_key_down('0);
	endtask

	// ------------------------------------------------------------
	// Display readback and checks.
	// ------------------------------------------------------------
	// Bit 4 marks a valid hex pattern.
	function automatic logic [4:0] seg_decode(input logic [6:0] s);
		case (s)
			7'h3f: return 5'h10;
			7'h06: return 5'h11;
			7'h5b: return 5'h12;
			7'h4f: return 5'h13;
			7'h66: return 5'h14;
			7'h6d: return 5'h15;
			7'h7d: return 5'h16;
			7'h07: return 5'h17;
			7'h7f: return 5'h18;
			7'h6f: return 5'h19;
			7'h77: return 5'h1a;
			7'h7c: return 5'h1b;
			7'h39: return 5'h1c;
			7'h5e: return 5'h1d;
			7'h79: return 5'h1e;
			7'h71: return 5'h1f;
			default: return 5'h00;
		endcase
	endfunction

	task automatic wait_dig(input logic [1:0] target, output bit ok);
		int n;
		n = 0;
		@(negedge clk);
		while (dig !== target && n < 4 * SCAN_CYCLES) begin
			@(negedge clk);
			n++;
		end
		ok = (dig === target);
	endtask

	task automatic read_display(output logic [VALUE_W-1:0] shown);
		bit ok;
		logic [4:0] lo;
		logic [4:0] hi;
		lo = '0;
		hi = '0;
		// Start on a fresh low digit.
		wait_dig(2'b10, ok);
		if (ok) begin
			wait_dig(2'b01, ok);
			lo = seg_decode(seg);
		end
		if (ok) begin
			wait_dig(2'b10, ok);
			hi = seg_decode(seg);
		end
		if (!ok) begin
			errors++;
			$display("Display scan stalled in test %s", test_name);
		end else if (!lo[4] || !hi[4]) begin
			errors++;
			$display("Display showed a pattern that is not a hex digit in test %s",
				test_name);
		end
		shown = {hi[3:0], lo[3:0]};
	endtask

	task automatic check_value(input string what, input logic [VALUE_W-1:0] exp,
		input logic [VALUE_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_state();
		logic [VALUE_W-1:0] shown;
		read_display(shown);
		check_value("display", exp_value, shown);
		check_flag("locked", exp_locked, locked);
		for (int i = 0; i < NUM_KEYS; i++) begin
			check_flag($sformatf("key_down[%0d]", i), 1'b0, key_down[i]);
		end
	endtask

	// A short pulse that must never reach key_down.
	task automatic glitch_only(input logic [NUM_KEYS-1:0] mask);
		int len;
		logic seen;
		seen = 1'b0;
		draw_bits(4, len);
		drive_keys(mask, 1'b0);
		wait_cycles(len + 1);
		drive_keys(mask, 1'b1);
		repeat (2 * HOLD) begin
			@(negedge clk);
			seen = seen | (|key_down);
		end
		check_flag("key_down on glitch", 1'b0, seen);
	endtask

	// ------------------------------------------------------------
	// Tests.
	// ------------------------------------------------------------
	task automatic begin_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_errors) begin
			$display("Test %s: ok", test_name);
		end else begin
			$display("Test %s: %0d errors", test_name, errors - test_errors);
		end
	endtask

	task automatic test_reset();
		begin_test("reset");
		check_state();
		end_test();
	endtask

	task automatic test_inc_dec();
		begin_test("inc_dec");
		repeat (3) press_keys(4'b0001, 1'b0);
		check_state();
		repeat (4) press_keys(4'b0010, 1'b0);
		check_state();
		end_test();
	endtask

	task automatic test_bounce();
		begin_test("bounce");
		press_keys(4'b0001, 1'b1);
		press_keys(4'b0001, 1'b1);
		press_keys(4'b0010, 1'b1);
		check_state();
		glitch_only(4'b0001);
		glitch_only(4'b0100);
		check_state();
		end_test();
	endtask

	// Starts from a nonzero value so that clear is visible.
	task automatic test_lock();
		begin_test("lock");
		press_keys(4'b0001, 1'b0);
		press_keys(4'b1000, 1'b0);
		check_state();
		press_keys(4'b0001, 1'b0);
		check_state();
		press_keys(4'b0010, 1'b0);
		check_state();
		press_keys(4'b0100, 1'b0);
		check_state();
		press_keys(4'b1000, 1'b0);
		press_keys(4'b0001, 1'b0);
		check_state();
		end_test();
	endtask

	task automatic test_simultaneous();
		begin_test("simultaneous");
		press_keys(4'b0001, 1'b0);
		press_keys(4'b0011, 1'b0);
		check_state();
		press_keys(4'b0101, 1'b0);
		check_state();
		end_test();
	endtask

	initial begin
		keys = '1;
		rst_n = 1'b0;
		lfsr = 8'd96;
		exp_value = '0;
		exp_locked = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		test_name = "init";
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_inc_dec();
		test_bounce();
		test_lock();
		test_simultaneous();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles in test %s", cycles, test_name);
			$display("Checks failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== dv/key_panel_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_panel_assertions (
	input wire clk,
	input wire rst_n,
	input wire [key_pkg::NUM_KEYS-1:0] flags,
	input wire [1:0] dig,
	input wire key_pkg::key_event_t key_event
);
	import key_pkg::*;

	logic ev_valid;

	assign ev_valid = key_event.valid;

	// Change pulses are single cycle.
	for (genvar i = 0; i < NUM_KEYS; i++) begin : g_flag
		flag_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
			flags[i] |=> !flags[i])
			else $error("key_flag %0d held longer than one cycle", i);
	end

	dig_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(dig))
		else $error("digit enables not one-hot: %b", dig);

	// At most one event per key in a burst.
	valid_burst: assert property (@(posedge clk) disable iff (!rst_n)
		!(ev_valid && $past(ev_valid, 1) && $past(ev_valid, 2)
		&& $past(ev_valid, 3) && $past(ev_valid, 4)))
		else $error("event valid held for more than four cycles");

endmodule

bind key_panel_top key_panel_assertions u_assertions (
	.clk(clk),
	.rst_n(rst_n),
	.flags(flags),
	.dig(dig),
	.key_event(key_event)
);

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);
	// 40 ns period.
	localparam int HALF_PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever begin
			#(HALF_PERIOD) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// ==== hw/key_panel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_panel_top #(
	parameter int DEBOUNCE_CYCLES = key_pkg::DEBOUNCE_DEFAULT
) (
	input wire clk,
	input wire rst_n,
	input wire [key_pkg::NUM_KEYS-1:0] keys,
	output logic [6:0] seg,
	output logic [1:0] dig,
	output logic locked,
	output logic [key_pkg::NUM_KEYS-1:0] key_down
);
	import key_pkg::*;

	logic [NUM_KEYS-1:0] flags;
	logic [NUM_KEYS-1:0] levels;
	key_event_t key_event;
	logic [VALUE_W-1:0] value;

	// ------------------------------------------------------------
	// One debounce filter per key.
	// ------------------------------------------------------------
	for (genvar i = 0; i < NUM_KEYS; i++) begin : g_filter
		key_filter #(
			.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
		) u_filter (
			.clk(clk),
			.rst_n(rst_n),
			.key_in(keys[i]),
			.key_flag(flags[i]),
			.key_state(levels[i])
		);
	end

	assign key_down = ~levels;

	key_event_encoder u_encoder (
		.clk(clk),
		.rst_n(rst_n),
		.flags(flags),
		.levels(levels),
		.key_event(key_event)
	);

	counter_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.key_event(key_event),
		.value(value),
		.locked(locked)
	);

	seg_scanner u_scanner (
		.clk(clk),
		.rst_n(rst_n),
		.value(value),
		.seg(seg),
		.dig(dig)
	);

endmodule

`default_nettype wire

// ==== hw/seg_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_scanner (
	input wire clk,
	input wire rst_n,
	input wire [key_pkg::VALUE_W-1:0] value,
	output logic [6:0] seg,
	output logic [1:0] dig
);
	import key_pkg::*;

	localparam int SCAN_W = $clog2(SCAN_CYCLES);

	logic [SCAN_W-1:0] scan_cnt;
	logic sel;
	logic [3:0] nibble;

	// Active high, segment a at bit 0.
	function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
		case (hex)
			4'h0: return 7'h3f;
			4'h1: return 7'h06;
			4'h2: return 7'h5b;
			4'h3: return 7'h4f;
			4'h4: return 7'h66;
			4'h5: return 7'h6d;
			4'h6: return 7'h7d;
			4'h7: return 7'h07;
			4'h8: return 7'h7f;
			4'h9: return 7'h6f;
			4'ha: return 7'h77;
			4'hb: return 7'h7c;
			4'hc: return 7'h39;
			4'hd: return 7'h5e;
			4'he: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	// Digit select swaps every SCAN_CYCLES cycles.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt <= '0;
			sel <= 1'b0;
		end else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
			scan_cnt <= '0;
			sel <= ~sel;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	assign nibble = sel ? value[7:4] : value[3:0];

	// Seg and dig registered together so they stay aligned.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dig <= 2'b01;
			seg <= hex_to_seg(4'h0);
		end else begin
			dig <= sel ? 2'b10 : 2'b01;
			seg <= hex_to_seg(nibble);
		end
	end

endmodule

`default_nettype wire

// ==== hw/counter_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module counter_ctrl (
	input wire clk,
	input wire rst_n,
	input key_pkg::key_event_t key_event,
	output logic [key_pkg::VALUE_W-1:0] value,
	output logic locked
);
	import key_pkg::*;

	opcode_e opcode;

	// ------------------------------------------------------------
	// Event decode. Releases are ignored.
	// ------------------------------------------------------------
	always_comb begin
		opcode = OP_NONE;
		if (key_event.valid && key_event.pressed) begin
			case (key_event.key_id)
				KEY_ID_W'(0): opcode = OP_INC;
				KEY_ID_W'(1): opcode = OP_DEC;
				KEY_ID_W'(2): opcode = OP_CLEAR;
				KEY_ID_W'(3): opcode = OP_LOCK;
				default: opcode = OP_NONE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// Counter and lock flag.
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			value <= '0;
		end else begin
			case (opcode)
				OP_INC: begin
					if (!locked) begin
						value <= value + VALUE_W'(1);
					end
				end
				OP_DEC: begin
					if (!locked) begin
						value <= value - VALUE_W'(1);
					end
				end
				// Clear is honoured while locked.
				OP_CLEAR: value <= '0;
				default: value <= value;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			locked <= 1'b0;
		end else if (opcode == OP_LOCK) begin
			locked <= ~locked;
		end
	end

endmodule

`default_nettype wire

// ==== hw/key_event_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_event_encoder (
	input wire clk,
	input wire rst_n,
	input wire [key_pkg::NUM_KEYS-1:0] flags,
	input wire [key_pkg::NUM_KEYS-1:0] levels,
	output key_pkg::key_event_t key_event
);
	import key_pkg::*;

	logic [NUM_KEYS-1:0] pending;
	logic [NUM_KEYS-1:0] saved_level;

	// Requests seen this cycle, new flags included.
	logic [NUM_KEYS-1:0] req;
	logic [NUM_KEYS-1:0] req_level;
	logic [NUM_KEYS-1:0] grant;
	logic [KEY_ID_W-1:0] grant_id;

	assign req = pending | flags;

	always_comb begin
		for (int i = 0; i < NUM_KEYS; i++) begin
			req_level[i] = flags[i] ? levels[i] : saved_level[i];
		end
	end

	// Lowest index wins.
	always_comb begin
		grant = '0;
		grant_id = '0;
		for (int i = NUM_KEYS - 1; i >= 0; i--) begin
			if (req[i]) begin
				grant = '0;
				grant[i] = 1'b1;
				grant_id = KEY_ID_W'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			pending <= req & ~grant;
		end
	end

	always_ff @(posedge clk) begin
		saved_level <= req_level;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key_event <= '0;
		end else begin
			key_event.valid <= |req;
			key_event.key_id <= grant_id;
			key_event.pressed <= ~req_level[grant_id];
		end
	end

endmodule

`default_nettype wire

// ==== hw/key_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_filter #(
	parameter int DEBOUNCE_CYCLES = key_pkg::DEBOUNCE_DEFAULT
) (
	input wire clk,
	input wire rst_n,
	input wire key_in,
	output logic key_flag,
	output logic key_state
);
	import key_pkg::*;

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	filter_state_e state;
	logic [CNT_W-1:0] cnt;
	logic en_cnt;
	logic cnt_full;

	logic key_in_sa;
	logic key_in_sb;
	logic key_tmpa;
	logic key_tmpb;
	logic nedge;
	logic pedge;

	// Two-stage synchronizer, idle level is released (high).
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key_in_sa <= 1'b1;
			key_in_sb <= 1'b1;
		end else begin
			key_in_sa <= key_in;
			key_in_sb <= key_in_sa;
		end
	end

	// Delay line for edge detection.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key_tmpa <= 1'b1;
			key_tmpb <= 1'b1;
		end else begin
			key_tmpa <= key_in_sb;
			key_tmpb <= key_tmpa;
		end
	end

	assign nedge = !key_tmpa && key_tmpb;
	assign pedge = key_tmpa && !key_tmpb;

	// ------------------------------------------------------------
	// Debounce FSM.
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			en_cnt <= 1'b0;
			key_flag <= 1'b0;
			key_state <= 1'b1;
		end else begin
			key_flag <= 1'b0;
			case (state)
				IDLE: begin
					if (nedge) begin
						state <= FILTER0;
						en_cnt <= 1'b1;
					end
				end
				FILTER0: begin
					if (cnt_full) begin
						key_flag <= 1'b1;
						key_state <= 1'b0;
						en_cnt <= 1'b0;
						state <= DOWN;
					end else if (pedge) begin
						// Bounce back up, start over.
						en_cnt <= 1'b0;
						state <= IDLE;
					end
				end
				DOWN: begin
					if (pedge) begin
						state <= FILTER1;
						en_cnt <= 1'b1;
					end
				end
				FILTER1: begin
					if (cnt_full) begin
						key_flag <= 1'b1;
						key_state <= 1'b1;
						en_cnt <= 1'b0;
						state <= IDLE;
					end else if (nedge) begin
						en_cnt <= 1'b0;
						state <= DOWN;
					end
				end
				default: begin
					state <= IDLE;
					en_cnt <= 1'b0;
					key_state <= 1'b1;
				end
			endcase
		end
	end

	// Hold counter.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (en_cnt) begin
			cnt <= cnt + 1'b1;
		end else begin
			cnt <= '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_full <= 1'b0;
		end else begin
			cnt_full <= en_cnt && (cnt == CNT_W'(DEBOUNCE_CYCLES - 1));
		end
	end

endmodule

`default_nettype wire

// ==== hw/key_pkg.sv ====
`default_nettype none

package key_pkg;

	// ------------------------------------------------------------
	// Sizes and timing defaults.
	// ------------------------------------------------------------
	localparam int NUM_KEYS = 4;
	localparam int KEY_ID_W = 2;
	localparam int VALUE_W = 8;

	// 20 ms at 50 MHz.
	localparam int DEBOUNCE_DEFAULT = 1_000_000;

	// Cycles each display digit stays lit.
	localparam int SCAN_CYCLES = 16;

	// ------------------------------------------------------------
	// Types.
	// ------------------------------------------------------------
	typedef enum logic [3:0] {
		IDLE    = 4'b0001,
		FILTER0 = 4'b0010,
		DOWN    = 4'b0100,
		FILTER1 = 4'b1000
	} filter_state_e;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_INC,
		OP_DEC,
		OP_CLEAR,
		OP_LOCK
	} opcode_e;

	typedef struct packed {
		logic valid;
		logic [KEY_ID_W-1:0] key_id;
		logic pressed;
	} key_event_t;

endpackage

`default_nettype wire
